//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = divSqrtTb
FILELIST  = verilog.f
OBJDIR    = obj_dir
PASS      = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)

//--- divSqrtFsm.sv
// Idle / busy / done control for the multi-cycle divide and square root
// Gates start, counts iterations and handles early exit, stall and flush

`timescale 1ns/100ps

module divSqrtFsm import divSqrtPkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   start,
  input  logic   hold,
  input  logic   flush,
  input  opT     op,
  input  logic   isSpecial,
  iterCtrlIf.fsm ctrl,
  output logic   busy,
  output logic   done,
  output logic   special
);

  fsmStateT state;
  stepT     stepCount;
  logic     startAcc;
  logic     lastStep;

  ///////////////////////////////
  // Start gating and status
  ///////////////////////////////

  // Requests only taken when idle and not stalled, others are dropped
  assign startAcc = start & (state == stIdle) & ~hold;

  // Busy covers the accept cycle too
  assign busy = (state == stBusy) | startAcc;
  assign done = (state == stDone);

  // Final step, or nothing left to do
  assign lastStep = (stepCount == stepT'(1)) | ctrl.residualZero;

  // Datapath control
  assign ctrl.load      = startAcc;
  assign ctrl.stepEn    = (state == stBusy);
  assign ctrl.stepsLeft = stepCount;

  ///////////////////////////////
  // State register
  ///////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= stIdle;
      stepCount <= '0;
    end else if (flush) begin
      // Abandon any request
      state <= stIdle;
    end else begin
      case (state)
        stIdle: begin
          if (startAcc) begin
            stepCount <= (op == opDiv) ? divSteps : sqrtSteps;
            // Special operands skip the iterations
            state     <= isSpecial ? stDone : stBusy;
          end
        end
        stBusy: begin
          stepCount <= stepCount - stepT'(1);
          if (lastStep) begin
            state <= stDone;
          end
        end
        stDone: begin
          // Stall keeps results visible
          if (!hold) begin
            state <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Special flag captured with the request
  always_ff @(posedge clk) begin
    if (reset) begin
      special <= 1'b0;
    end else if (startAcc) begin
      special <= isSpecial;
    end
  end

endmodule

//--- divSqrtInput.txt
// Columns: op (0 div, 1 sqrt), operandA, operandB, hold cycles, flush after,
// expected result, expected remainder, expected special; op F ends the list
// Division
0 00C8 0007 0 0 001C 0004 0
0 FFFF 0001 0 0 FFFF 0000 0
0 8000 0002 0 0 4000 0000 0
0 1234 0056 0 0 0036 0010 0
0 0005 0009 0 0 0000 0005 0
0 FFFF FFFF 0 0 0001 0000 0
0 ABCD 0100 0 0 00AB 00CD 0
0 7FFF 0003 0 0 2AAA 0001 0
0 9C40 00C8 0 0 00C8 0000 0
0 0001 0002 0 0 0000 0001 0
// Division special cases
0 1234 0000 0 0 FFFF 1234 1
0 0000 0007 0 0 0000 0000 1
0 0000 0000 0 0 FFFF 0000 1
// Square root, operandB unused
1 0000 0000 0 0 0000 0000 1
1 0001 0000 0 0 0001 0000 1
1 0002 0000 0 0 0001 0001 0
1 0003 0000 0 0 0001 0002 0
1 0010 0000 0 0 0004 0000 0
1 FFFF 0000 0 0 00FF 01FE 0
1 4000 0000 0 0 0080 0000 0
1 0063 0000 0 0 0009 0012 0
1 1000 0000 0 0 0040 0000 0
1 2710 0000 0 0 0064 0000 0
1 FE01 0000 0 0 00FF 0000 0
// Stall in done
0 0064 000A 3 0 000A 0000 0
1 0051 0000 2 0 0009 0000 0
0 0000 0005 4 0 0000 0000 1
1 0001 0000 1 0 0001 0000 1
// Flush while busy, then a normal request
0 FFFF 0003 0 2 5555 0000 0
0 1234 0056 0 0 0036 0010 0
1 FFFF 0000 0 1 00FF 01FE 0
1 0063 0000 0 0 0009 0012 0
F 0000 0000 0 0 0000 0000 0

//--- divSqrtIter.sv
// Shared radix-2 iteration datapath
// Restoring division takes one dividend bit per step, square root takes two
// operand bits per step; both use the same compare-subtract

`timescale 1ns/100ps

module divSqrtIter import divSqrtPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  opT      op,
  input  operandT operandA,
  input  operandT operandB,
  input  logic    isSpecial,
  input  operandT specialQuot,
  input  operandT specialRem,
  iterCtrlIf.iter ctrl,
  output operandT result,
  output operandT remainder
);

  // Request held for the whole iteration
  opT      opReg;
  operandT divisor;
  // Unconsumed operand bits with the MSB first
  operandT shiftA;
  operandT nextA;

  // Quotient or root shifted in from the LSB
  operandT quot;
  rootT    root;

  // Partial remainder and trial subtraction
  remT     rem;
  remT     shiftRem;
  remT     trialSub;
  logic [dataWidth+1:0] diff;
  logic    borrow;

  // Root never grows past rootWidth bits
  assign root = quot[rootWidth-1:0];

  ///////////////////////////////
  // Compare-subtract
  ///////////////////////////////

  always_comb begin
    if (opReg == opDiv) begin
      // Bring down one dividend bit and subtract the divisor
      shiftRem = {rem[dataWidth-1:0], shiftA[dataWidth-1]};
      trialSub = {1'b0, divisor};
      nextA    = shiftA << 1;
    end else begin
      // Bring down two bits and subtract 4*root + 1
      shiftRem = {rem[dataWidth-2:0], shiftA[dataWidth-1 -: 2]};
      trialSub = remT'({root, 2'b01});
      nextA    = shiftA << 2;
    end
  end

  // Extra top bit catches the borrow
  assign diff   = {1'b0, shiftRem} - {1'b0, trialSub};
  assign borrow = diff[dataWidth+1];

  // Zero remainder with zero bits left means every later digit is 0
  assign ctrl.residualZero = (rem == '0) & (shiftA == '0);

  ///////////////////////////////
  // Result registers
  ///////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      quot <= '0;
      rem  <= '0;
    end else if (ctrl.load) begin
      if (isSpecial) begin
        quot <= specialQuot;
        rem  <= {1'b0, specialRem};
      end else begin
        quot <= '0;
        rem  <= '0;
      end
    end else if (ctrl.stepEn) begin
      if (ctrl.residualZero) begin
        // Early exit appends the remaining zero digits at once
        quot <= quot << ctrl.stepsLeft;
      end else begin
        quot <= {quot[dataWidth-2:0], ~borrow};
        // A borrow restores the shifted remainder
        rem  <= borrow ? shiftRem : diff[dataWidth:0];
      end
    end
  end

  ///////////////////////////////
  // Operand registers
  ///////////////////////////////

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      opReg   <= op;
      divisor <= operandB;
      shiftA  <= operandA;
    end else if (ctrl.stepEn) begin
      shiftA <= nextA;
    end
  end

  // Root already sits zero-extended in the low bits
  assign result    = quot;
  // Both remainders fit in dataWidth bits
  assign remainder = rem[dataWidth-1:0];

endmodule

//--- divSqrtPkg.sv
// Shared widths, vector types and enums for the divide / square-root unit
// Every design file takes what it needs by a wildcard import

package divSqrtPkg;

  ///////////////////////////////
  // Widths
  ///////////////////////////////

  // Operand, quotient and division remainder width
  localparam int dataWidth = 16;
  // Square root is half the operand width
  localparam int rootWidth = 8;

  ///////////////////////////////
  // Vector types
  ///////////////////////////////

  // Operands, quotients and division remainders
  typedef logic [dataWidth-1:0] operandT;
  // Integer square root
  typedef logic [rootWidth-1:0] rootT;
  // Partial remainder, one bit wider than an operand
  typedef logic [dataWidth:0]   remT;
  // Iteration counter, holds up to divSteps
  typedef logic [4:0]           stepT;

  // Iterations per operation, one quotient bit or one root bit each
  localparam stepT divSteps  = 5'd16;
  localparam stepT sqrtSteps = 5'd8;

  ///////////////////////////////
  // Enums
  ///////////////////////////////

  // Operation chosen per request
  typedef enum logic {
    opDiv,
    opSqrt
  } opT;

  // Control FSM states
  typedef enum logic [1:0] {
    stIdle,
    stBusy,
    stDone
  } fsmStateT;

endpackage

//--- divSqrtSpecial.sv
// Special-operand detection for the divide / square-root unit
// Combinational; results are loaded in place of the operands so no iteration runs

`timescale 1ns/100ps

module divSqrtSpecial import divSqrtPkg::*; (
  input  opT      op,
  input  operandT operandA,
  input  operandT operandB,
  output logic    isSpecial,
  output operandT specialQuot,
  output operandT specialRem
);

  logic divByZero;
  logic zeroDividend;
  logic sqrtTrivial;

  ///////////////////////////////
  // Detection
  ///////////////////////////////

  // Zero divisor wins over a zero dividend
  assign divByZero    = (op == opDiv) & (operandB == '0);
  assign zeroDividend = (op == opDiv) & (operandA == '0);

  // Root of 0 or 1 is the operand itself
  assign sqrtTrivial  = (op == opSqrt) & (operandA[dataWidth-1:1] == '0);

  assign isSpecial = divByZero | zeroDividend | sqrtTrivial;

  ///////////////////////////////
  // Immediate results
  ///////////////////////////////

  always_comb begin
    if (divByZero) begin
      // All-ones quotient, dividend passes to remainder
      specialQuot = '1;
      specialRem  = operandA;
    end else if (sqrtTrivial) begin
      specialQuot = operandA;
      specialRem  = '0;
    end else begin
      // Zero dividend, also the unused default
      specialQuot = '0;
      specialRem  = '0;
    end
  end

endmodule

//--- divSqrtTb.sv
// Testbench for the divide / square-root unit
// Runs the directed requests from divSqrtInput.txt, then LFSR random requests,
// and checks results, special flag, stall, flush and start gating

`timescale 1ns/100ps

module divSqrtTb import divSqrtPkg::*; ();

  localparam int clkPeriod   = 40;
  localparam int fieldCount  = 8;
  localparam int maxLines    = 64;
  localparam int randomCount = 200;

  logic    clk;
  logic    reset;
  logic    start;
  opT      op;
  operandT operandA;
  operandT operandB;
  logic    hold;
  logic    flush;
  logic    busy;
  logic    done;
  logic    special;
  operandT result;
  operandT remainder;

  // Vector file with eight fields per request
  logic [31:0] vecMem [0:fieldCount*maxLines-1];
  int          vecCount;
  logic        loaded = 1'b0;
  logic [31:0] lfsrState;

  int   valueErrors = 0;
  int   flowErrors = 0;
  int   doneRises = 0;
  int   expectedDones = 0;
  logic doneLast = 1'b0;

  divSqrtUnit dut (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .op        (op),
    .operandA  (operandA),
    .operandB  (operandB),
    .hold      (hold),
    .flush     (flush),
    .busy      (busy),
    .done      (done),
    .special   (special),
    .result    (result),
    .remainder (remainder)
  );

  initial clk = 1'b0;
  always #(clkPeriod / 2) clk = ~clk;

  // Every rising done counts as one finished request
  always @(negedge clk) begin
    if (done && !doneLast) begin
      doneRises++;
    end
    doneLast = done;
  end

  ///////////////////////////////
  // Checks and models
  ///////////////////////////////

  task automatic checkOperand(input string name, input operandT got, input operandT expected);
    if (got !== expected) begin
      $display("error at %0d ns: %s is %h, expected %h", $time, name, got, expected);
      valueErrors++;
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("error at %0d ns: %s is %b, expected %b", $time, name, got, expected);
      valueErrors++;
    end
  endtask

  // Galois LFSR with polynomial x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    int          i;
    value = '0;
    for (i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  // Reference results straight from the arithmetic
  task automatic modelResult(input opT reqOp, input operandT a, input operandT b,
                             output operandT expRes, output operandT expRem,
                             output logic expSpecial);
    int aInt;
    int bInt;
    int r;
    aInt = int'(a);
    bInt = int'(b);
    expSpecial = 1'b0;
    if (reqOp == opDiv) begin
      if (bInt == 0) begin
        expRes = '1;
        expRem = a;
        expSpecial = 1'b1;
      end else begin
        expRes = operandT'(aInt / bInt);
        expRem = operandT'(aInt % bInt);
        expSpecial = (aInt == 0);
      end
    end else begin
      r = 0;
      while ((r + 1) * (r + 1) <= aInt) begin
        r++;
      end
      expRes = operandT'(r);
      expRem = operandT'(aInt - r * r);
      expSpecial = (aInt < 2);
    end
  endtask

  ///////////////////////////////
  // Stimulus
  ///////////////////////////////

  task automatic resetDut();
    reset    <= 1'b1;
    start    <= 1'b0;
    op       <= opDiv;
    operandA <= '0;
    operandB <= '0;
    hold     <= 1'b0;
    flush    <= 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  endtask

  // One request from start strobe to return to idle
  task automatic runRequest(input opT reqOp, input operandT a, input operandT b,
                            input int holdCycles, input int flushAfter,
                            input operandT expRes, input operandT expRem,
                            input logic expSpecial);
    int      i;
    int      cycles;
    logic    sawDone;
    @(posedge clk);
    start    <= 1'b1;
    op       <= reqOp;
    operandA <= a;
    operandB <= b;
    hold     <= 1'b0;
    flush    <= 1'b0;
    @(negedge clk);
    // busy already high in the accept cycle
    checkFlag("busy", busy, 1'b1);
    @(posedge clk);
    start <= 1'b0;
    hold  <= (holdCycles > 0) && (flushAfter == 0);
    @(negedge clk);
    // Special operands finish right after the accept edge
    checkFlag("done", done, expSpecial);

    if (flushAfter > 0) begin
      for (i = 1; i <= flushAfter; i++) begin
        @(posedge clk);
        if (i == flushAfter) begin
          flush <= 1'b1;
        end
      end
      @(posedge clk);
      flush <= 1'b0;
      @(negedge clk);
      checkFlag("busy", busy, 1'b0);
      checkFlag("done", done, 1'b0);
      sawDone = 1'b0;
      repeat (int'(divSteps) + 2) begin
        @(negedge clk);
        sawDone = sawDone | done;
      end
      if (sawDone) begin
        $display("Flushed request still raised done at %0d ns", $time);
        flowErrors++;
      end
      return;
    end

    expectedDones++;
    if (!expSpecial) begin
      // A stray start while busy must be dropped
      @(posedge clk);
      start    <= 1'b1;
      op       <= (reqOp == opDiv) ? opSqrt : opDiv;
      operandA <= ~a;
      operandB <= b + operandT'(1);
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
    end

    cycles = 0;
    while (!done && cycles < int'(divSteps) + 2) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      $display("No done within %0d cycles for operand %h at %0d ns", cycles, a, $time);
      flowErrors++;
      @(posedge clk);
      hold <= 1'b0;
      return;
    end
    checkOperand("result", result, expRes);
    checkOperand("remainder", remainder, expRem);
    checkFlag("special", special, expSpecial);

    // Results stay frozen until hold drops
    for (i = 1; i <= holdCycles; i++) begin
      @(posedge clk);
      if (i == holdCycles) begin
        hold <= 1'b0;
      end
      @(negedge clk);
      checkFlag("done", done, 1'b1);
      checkOperand("result", result, expRes);
      checkOperand("remainder", remainder, expRem);
    end
    @(posedge clk);
    @(negedge clk);
    checkFlag("done", done, 1'b0);
    checkFlag("busy", busy, 1'b0);
  endtask

  ///////////////////////////////
  // Main sequence
  ///////////////////////////////

  initial begin
    int          line;
    int          base;
    int          n;
    opT          rOp;
    operandT     a;
    operandT     b;
    operandT     expRes;
    operandT     expRem;
    logic        expSpecial;
    lfsrState = 32'h385;
    $readmemh("divSqrtInput.txt", vecMem);
    // Op field F marks the end of the vectors
    vecCount = 0;
    while (vecCount < maxLines && vecMem[vecCount * fieldCount] !== 32'hF) begin
      vecCount++;
    end
    if (vecCount == maxLines) begin
      $display("Vector file has no end marker, directed requests skipped");
      flowErrors++;
      vecCount = 0;
    end
    loaded = 1'b1;
    resetDut();

    for (line = 0; line < vecCount; line++) begin
      base = line * fieldCount;
      runRequest(vecMem[base][0] ? opSqrt : opDiv,
                 vecMem[base + 1][15:0], vecMem[base + 2][15:0],
                 int'(vecMem[base + 3]), int'(vecMem[base + 4]),
                 vecMem[base + 5][15:0], vecMem[base + 6][15:0], vecMem[base + 7][0]);
    end

    for (n = 0; n < randomCount; n++) begin
      rOp = (randomBits(1) == 32'd1) ? opSqrt : opDiv;
      a = operandT'(randomBits(16));
      b = operandT'(randomBits(16));
      // Occasional small divisors and dividends including zero
      if (randomBits(2) == 32'd0) begin
        b = b >> 12;
      end
      if (randomBits(3) == 32'd0) begin
        a = a >> 10;
      end
      modelResult(rOp, a, b, expRes, expRem, expSpecial);
      runRequest(rOp, a, b, 0, 0, expRes, expRem, expSpecial);
    end

    if (doneRises != expectedDones) begin
      $display("Saw %0d done pulses where %0d requests completed", doneRises, expectedDones);
      flowErrors++;
    end
    $display("Errors: %0d value, %0d flow", valueErrors, flowErrors);
    if (valueErrors == 0 && flowErrors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog sized from the number of requests
  initial begin
    wait (loaded);
    #((longint'(vecCount + randomCount) * (int'(divSteps) + 4) + 500) * clkPeriod);
    $display("Timeout, the run did not finish in time");
    $display("Test failures found");
    $finish;
  end

endmodule

//--- divSqrtUnit.sv
// Top level of the multi-cycle unsigned divide / integer square-root unit
// start is a one-cycle strobe; busy, done and the results are levels

`timescale 1ns/100ps

module divSqrtUnit import divSqrtPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    start,
  input  opT      op,
  input  operandT operandA,
  input  operandT operandB,
  input  logic    hold,
  input  logic    flush,
  output logic    busy,
  output logic    done,
  output logic    special,
  output operandT result,
  output operandT remainder
);

  // Special-case wires
  logic    isSpecial;
  operandT specialQuot;
  operandT specialRem;

  // FSM to datapath control
  iterCtrlIf ctrlBus ();

  ///////////////////////////////
  // Blocks
  ///////////////////////////////

  divSqrtFsm fsm (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .hold      (hold),
    .flush     (flush),
    .op        (op),
    .isSpecial (isSpecial),
    .ctrl      (ctrlBus.fsm),
    .busy      (busy),
    .done      (done),
    .special   (special)
  );

  divSqrtSpecial specialCase (
    .op          (op),
    .operandA    (operandA),
    .operandB    (operandB),
    .isSpecial   (isSpecial),
    .specialQuot (specialQuot),
    .specialRem  (specialRem)
  );

  divSqrtIter iter (
    .clk         (clk),
    .reset       (reset),
    .op          (op),
    .operandA    (operandA),
    .operandB    (operandB),
    .isSpecial   (isSpecial),
    .specialQuot (specialQuot),
    .specialRem  (specialRem),
    .ctrl        (ctrlBus.iter),
    .result      (result),
    .remainder   (remainder)
  );

endmodule

//--- iterCtrlIf.sv
// Control and status between the FSM and the iteration datapath
// The FSM side drives load, stepEn and stepsLeft, the datapath returns residualZero

`timescale 1ns/100ps

interface iterCtrlIf import divSqrtPkg::*; ();

  // Accepted start, one cycle
  logic load;
  // High for every busy cycle
  logic stepEn;
  // Steps still to run, counting the current one
  stepT stepsLeft;
  // Nothing left to subtract, early exit allowed
  logic residualZero;

  modport fsm (
    output load,
    output stepEn,
    output stepsLeft,
    input  residualZero
  );

  modport iter (
    input  load,
    input  stepEn,
    input  stepsLeft,
    output residualZero
  );

endinterface

//--- verilog.f
divSqrtPkg.sv
iterCtrlIf.sv
divSqrtFsm.sv
divSqrtSpecial.sv
divSqrtIter.sv
divSqrtUnit.sv
divSqrtTb.sv
